//--- project.f
rot_pkg.sv
rot_bus_if.sv
rot_rng_if.sv
rot_xbar.sv
rot_puf.sv
rot_entropy_src.sv
rot_top.sv
rot_top_sva.sv
tb_rot_top.sv

//--- Bender.yml
package:
  name: rot_entropy

sources:
  - rot_pkg.sv
  - rot_bus_if.sv
  - rot_rng_if.sv
  - rot_xbar.sv
  - rot_puf.sv
  - rot_entropy_src.sv
  - rot_top.sv
  - target: simulation
    files:
      - rot_top_sva.sv
      - tb_rot_top.sv

//--- tb_rot_top.sv
`timescale 1ns/1ps

module tb_rot_top
  import rot_pkg::*;
();

  localparam int REP_LIMIT = HEALTH_REP_LIMIT_DEF;
  localparam int TIMEOUT = 200;

  logic                  clk_i;
  logic                  rst_i;
  logic                  bus_req_i;
  logic                  bus_we_i;
  logic [BUS_ADDR_W-1:0] bus_addr_i;
  logic [BUS_DATA_W-1:0] bus_wdata_i;
  logic [BUS_DATA_W-1:0] bus_rdata_o;
  logic                  bus_ack_o;
  logic [RNG_W-1:0]      rng_b_i;
  logic                  rng_valid_i;
  logic                  es_rng_enable_o;
  logic                  intr_es_entropy_valid_o;
  logic                  intr_es_health_test_failed_o;

  // pending checks for the compare process
  string                 name_q[$];
  logic [BUS_DATA_W-1:0] exp_q[$];
  logic [BUS_DATA_W-1:0] act_q[$];
  time                   when_q[$];
  event                  chk_ev;
  int                    checks = 0;
  int                    errors = 0;
  int                    test_base = 0;
  logic [31:0]           lcg_state = 32'h08fa4cd4;
  logic [RNG_W-1:0]      nib_q[$];
  logic                  hf_seen = 1'b0;

  rot_top #(
    .HEALTH_REP_LIMIT(REP_LIMIT)
  ) uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // galois step shifts right and folds the mask on a set lsb
  function automatic logic [LFSR_W-1:0] lfsr_next(input logic [LFSR_W-1:0] s);
    return (s >> 1) ^ (s[0] ? PUF_LFSR_TAPS : '0);
  endfunction

  // eight nibbles packed with the first one in the low bits
  function automatic logic [BUS_DATA_W-1:0] pack_nibbles(input int first);
    logic [BUS_DATA_W-1:0] w;
    w = '0;
    for (int i = 0; i < 8; i++) begin
      w[i*RNG_W +: RNG_W] = nib_q[first + i];
    end
    return w;
  endfunction

  function automatic logic [BUS_DATA_W-1:0] puf_word(input logic [LFSR_W-1:0] seed);
    logic [BUS_DATA_W-1:0] w;
    logic [LFSR_W-1:0]     s;
    s = seed;
    for (int i = 0; i < 8; i++) begin
      s = lfsr_next(s);
      w[i*RNG_W +: RNG_W] = s[RNG_W-1:0];
    end
    return w;
  endfunction

  // longest run of equal nibbles
  function automatic int longest_run(input int first, input int count);
    int run;
    int best;
    run = 0;
    best = 0;
    for (int i = first; i < first + count; i++) begin
      if (i > first && nib_q[i] == nib_q[i-1]) run++;
      else run = 1;
      if (run > best) best = run;
    end
    return best;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    name_q.push_back(name);
    exp_q.push_back(exp_v);
    act_q.push_back(act_v);
    when_q.push_back($time);
    -> chk_ev;
  endtask

  initial begin
    string       nm;
    logic [31:0] e;
    logic [31:0] a;
    time         t;
    forever begin
      @(chk_ev);
      while (name_q.size() > 0) begin
        nm = name_q.pop_front();
        e = exp_q.pop_front();
        a = act_q.pop_front();
        t = when_q.pop_front();
        checks++;
        if (a !== e) begin
          errors++;
          $display("mismatch at %0t: %s expected 0x%08h got 0x%08h", t, nm, e, a);
        end
      end
    end
  end

  // health interrupt watch
  always @(negedge clk_i) begin
    if (!rst_i && intr_es_health_test_failed_o) hf_seen = 1'b1;
  end

  task automatic bus_access(input logic we, input logic [BUS_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    n = 0;
    @(posedge clk_i);
    bus_req_i   <= 1'b1;
    bus_we_i    <= we;
    bus_addr_i  <= addr;
    bus_wdata_i <= wdata;
    @(posedge clk_i);
    bus_req_i <= 1'b0;
    @(negedge clk_i);
    while (!bus_ack_o && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    rdata = bus_rdata_o;
    if (!bus_ack_o) begin
      errors++;
      $display("timeout: no bus_ack_o for the access to address 0x%02h", addr);
    end
  endtask

  task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_access(1'b1, addr, wdata, unused);
  endtask

  task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr, output logic [31:0] rdata);
    bus_access(1'b0, addr, '0, rdata);
  endtask

  // one nibble per cycle on the external rng pins
  task automatic drive_nibbles(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      @(posedge clk_i);
      rng_b_i     <= nib_q[i];
      rng_valid_i <= 1'b1;
    end
    @(posedge clk_i);
    rng_valid_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic wait_entropy();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!intr_es_entropy_valid_o && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (!intr_es_entropy_valid_o) begin
      errors++;
      $display("timeout: intr_es_entropy_valid_o never went high");
    end
  endtask

  task automatic end_test(input string name);
    int n;
    n = 0;
    while (name_q.size() > 0 && n < 10) begin
      #1;
      n++;
    end
    if (name_q.size() > 0) begin
      errors++;
      $display("compare process did not drain its checks");
    end
    $display("test %s finished with %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] exp_w;
    $timeformat(-9, 0, " ns", 0);
    rst_i       = 1'b1;
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    bus_addr_i  = '0;
    bus_wdata_i = '0;
    rng_b_i     = '0;
    rng_valid_i = 1'b0;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;

    // registers and the unmapped slot
    bus_read({SLOT_PUF, REG_PUF_CTRL}, rd);
    expect_eq("bus_rdata_o PUF_CTRL", 32'd1, rd);
    bus_write({SLOT_PUF, REG_PUF_SEED}, 32'h1234);
    bus_read({SLOT_PUF, REG_PUF_SEED}, rd);
    expect_eq("bus_rdata_o PUF_SEED", 32'h1234, rd);
    bus_read({2'd2, 6'h00}, rd);
    expect_eq("bus_rdata_o slot 2", BUS_ERR_DATA, rd);
    expect_eq("es_rng_enable_o", 32'd0, es_rng_enable_o);
    end_test("registers");

    // external entropy from eight lcg nibbles
    bus_write({SLOT_ES, REG_ES_CTRL}, 32'd1);
    nib_q.delete();
    for (int i = 0; i < 8; i++) begin
      lcg_state = lcg_next(lcg_state);
      nib_q.push_back(lcg_state[31:28]);
    end
    drive_nibbles(0, 8);
    wait_entropy();
    bus_read({SLOT_ES, REG_ES_DATA}, rd);
    expect_eq("bus_rdata_o ES_DATA", pack_nibbles(0), rd);
    expect_eq("intr_es_entropy_valid_o", 32'd0, intr_es_entropy_valid_o);
    end_test("external_entropy");

    // a whole extra word driven while one is held must be dropped
    nib_q.delete();
    for (int i = 0; i < 16; i++) begin
      lcg_state = lcg_next(lcg_state);
      nib_q.push_back(lcg_state[31:28]);
    end
    drive_nibbles(0, 8);
    wait_entropy();
    expect_eq("es_rng_enable_o", 32'd0, es_rng_enable_o);
    drive_nibbles(8, 8);
    expect_eq("es_rng_enable_o", 32'd0, es_rng_enable_o);
    bus_read({SLOT_ES, REG_ES_DATA}, rd);
    expect_eq("bus_rdata_o ES_DATA", pack_nibbles(0), rd);
    end_test("back_pressure");

    // restart drops any partial word and the health count
    bus_write({SLOT_ES, REG_ES_CTRL}, 32'd0);
    bus_write({SLOT_ES, REG_ES_CTRL}, 32'd1);
    nib_q.delete();
    for (int i = 0; i < REP_LIMIT; i++) nib_q.push_back(4'h5);
    drive_nibbles(0, REP_LIMIT);
    exp_w = (longest_run(0, REP_LIMIT) >= REP_LIMIT) ? 32'd1 : 32'd0;
    expect_eq("intr_es_health_test_failed_o", exp_w, intr_es_health_test_failed_o);
    bus_read({SLOT_ES, REG_ES_STATUS}, rd);
    expect_eq("ES_STATUS bit1", exp_w, rd[1]);
    bus_write({SLOT_ES, REG_ES_CTRL}, 32'd1);
    expect_eq("intr_es_health_test_failed_o", 32'd0, intr_es_health_test_failed_o);
    bus_read({SLOT_ES, REG_ES_STATUS}, rd);
    expect_eq("ES_STATUS bit1", 32'd0, rd[1]);

    // runs one short of the limit spread over two words
    bus_write({SLOT_ES, REG_ES_CTRL}, 32'd0);
    bus_write({SLOT_ES, REG_ES_CTRL}, 32'd1);
    hf_seen = 1'b0;
    nib_q.delete();
    for (int i = 0; i < 16; i++) nib_q.push_back(RNG_W'(i / (REP_LIMIT - 1) + 1));
    for (int k = 0; k < 2; k++) begin
      drive_nibbles(k * 8, 8);
      wait_entropy();
      bus_read({SLOT_ES, REG_ES_DATA}, rd);
      expect_eq("bus_rdata_o ES_DATA", pack_nibbles(k * 8), rd);
    end
    exp_w = (longest_run(0, 16) >= REP_LIMIT) ? 32'd1 : 32'd0;
    expect_eq("intr_es_health_test_failed_o seen", exp_w, hf_seen);
    end_test("health_test");

    // puf entropy from a known seed
    bus_write({SLOT_ES, REG_ES_CTRL}, 32'd0);
    bus_write({SLOT_PUF, REG_PUF_SEED}, 32'h3c5a);
    bus_write({SLOT_PUF, REG_PUF_CTRL}, 32'd0);
    bus_write({SLOT_ES, REG_ES_CTRL}, 32'd1);
    wait_entropy();
    bus_read({SLOT_ES, REG_ES_DATA}, rd);
    expect_eq("bus_rdata_o ES_DATA", puf_word(16'h3c5a), rd);
    end_test("puf_entropy");

    errors = errors + uut.u_sva.fail_cnt;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- rot_top_sva.sv
`timescale 1ns/1ps

module rot_top_sva
  import rot_pkg::*;
(
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  bus_req_i,
  input logic                  bus_ack_o,
  input logic [BUS_DATA_W-1:0] bus_rdata_o,
  input logic                  es_rng_enable_o,
  input logic                  intr_es_entropy_valid_o,
  input logic                  intr_es_health_test_failed_o
);

  // count of failed assertions
  int fail_cnt = 0;

  // ack exactly one cycle after each request
  ack_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_req_i |=> bus_ack_o)
    else begin
      $error("bus_ack_o missing one cycle after bus_req_i");
      fail_cnt++;
    end

  // no ack without a request one cycle earlier
  no_spurious_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    !bus_req_i |=> !bus_ack_o)
    else begin
      $error("bus_ack_o without a request one cycle earlier");
      fail_cnt++;
    end

  // held word blocks new samples
  hold_blocks_rng: assert property (@(posedge clk_i) disable iff (rst_i)
    intr_es_entropy_valid_o |-> !es_rng_enable_o)
    else begin
      $error("es_rng_enable_o high while a word is held");
      fail_cnt++;
    end

  // outputs settle after the first reset edge
  quiet_in_reset: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) |-> !bus_ack_o && (bus_rdata_o == '0) && !es_rng_enable_o
      && !intr_es_entropy_valid_o && !intr_es_health_test_failed_o)
    else begin
      $error("outputs not low during reset");
      fail_cnt++;
    end

endmodule

bind rot_top rot_top_sva u_sva (
  .clk_i                        (clk_i),
  .rst_i                        (rst_i),
  .bus_req_i                    (bus_req_i),
  .bus_ack_o                    (bus_ack_o),
  .bus_rdata_o                  (bus_rdata_o),
  .es_rng_enable_o              (es_rng_enable_o),
  .intr_es_entropy_valid_o      (intr_es_entropy_valid_o),
  .intr_es_health_test_failed_o (intr_es_health_test_failed_o)
);

//--- rot_top.sv
`timescale 1ns/1ps

module rot_top
  import rot_pkg::*;
#(
  parameter int HEALTH_REP_LIMIT = HEALTH_REP_LIMIT_DEF
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // host register bus
  input  logic                  bus_req_i,
  input  logic                  bus_we_i,
  input  logic [BUS_ADDR_W-1:0] bus_addr_i,
  input  logic [BUS_DATA_W-1:0] bus_wdata_i,
  output logic [BUS_DATA_W-1:0] bus_rdata_o,
  output logic                  bus_ack_o,
  // external rng
  input  logic [RNG_W-1:0]      rng_b_i,
  input  logic                  rng_valid_i,
  output logic                  es_rng_enable_o,
  // interrupts
  output logic                  intr_es_entropy_valid_o,
  output logic                  intr_es_health_test_failed_o
);

  // one bus slot per peripheral
  rot_bus_if es_bus ();
  rot_bus_if puf_bus ();
  // puf to entropy source samples
  rot_rng_if rng ();

  rot_xbar u_xbar (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (bus_req_i),
    .we_i    (bus_we_i),
    .addr_i  (bus_addr_i),
    .wdata_i (bus_wdata_i),
    .rdata_o (bus_rdata_o),
    .ack_o   (bus_ack_o),
    .es_o    (es_bus),
    .puf_o   (puf_bus)
  );

  rot_entropy_src #(
    .HEALTH_REP_LIMIT(HEALTH_REP_LIMIT)
  ) u_entropy_src (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .bus_i                (es_bus),
    .rng_i                (rng),
    .rng_b_i              (rng_b_i),
    .rng_valid_i          (rng_valid_i),
    .rng_enable_o         (es_rng_enable_o),
    .intr_entropy_valid_o (intr_es_entropy_valid_o),
    .intr_health_failed_o (intr_es_health_test_failed_o)
  );

  // also owns rng_mode for the sample mux
  rot_puf u_puf (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus_i (puf_bus),
    .rng_o (rng)
  );

endmodule

//--- rot_entropy_src.sv
`timescale 1ns/1ps

module rot_entropy_src
  import rot_pkg::*;
#(
  parameter int HEALTH_REP_LIMIT = HEALTH_REP_LIMIT_DEF
) (
  input  logic             clk_i,
  input  logic             rst_i,
  rot_bus_if.device        bus_i,
  rot_rng_if.sink          rng_i,
  input  logic [RNG_W-1:0] rng_b_i,
  input  logic             rng_valid_i,
  output logic             rng_enable_o,
  output logic             intr_entropy_valid_o,
  output logic             intr_health_failed_o
);

  // nibbles per word and counter widths
  localparam int NIB_N = BUS_DATA_W / RNG_W;
  localparam int IDX_W = $clog2(NIB_N);
  localparam int CNT_W = $clog2(HEALTH_REP_LIMIT + 1);

  logic                  enable_q;
  logic [RNG_W-1:0]      smp;
  logic                  smp_vld;
  logic                  take;
  logic [IDX_W-1:0]      idx_q;
  logic [BUS_DATA_W-1:0] pack_q;
  logic [BUS_DATA_W-1:0] pack_next;
  logic [BUS_DATA_W-1:0] hold_q;
  logic                  full_q;
  logic [RNG_W-1:0]      prev_q;
  logic [CNT_W-1:0]      rep_q;
  logic [CNT_W-1:0]      rep_next;
  logic                  fail_q;
  logic                  wr_ctrl;
  logic                  rd_data;
  logic                  ack_q;
  logic [BUS_DATA_W-1:0] rdata_q;

  // sample source, same selection as the puf mode mux
  always_comb begin
    if (!rng_i.rng_mode) begin
      smp     = rng_i.rng4bit;
      smp_vld = rng_i.rng4bit_done;
    end else begin
      smp     = rng_b_i;
      smp_vld = rng_valid_i;
    end
  end

  // ask for samples only with room to store them
  assign rng_i.es_rng_req = enable_q && !full_q;
  assign rng_enable_o     = enable_q && !full_q;

  // late samples while a word is held get dropped here
  assign take = smp_vld && enable_q && !full_q;

  assign wr_ctrl = bus_i.req && bus_i.we && (bus_i.addr == REG_ES_CTRL);
  assign rd_data = bus_i.req && !bus_i.we && (bus_i.addr == REG_ES_DATA);

  // low nibble first
  always_comb begin
    pack_next = pack_q;
    pack_next[idx_q*RNG_W +: RNG_W] = smp;
  end

  // repeat count, no previous sample while the count is zero
  always_comb begin
    if ((rep_q != '0) && (smp == prev_q)) begin
      rep_next = (rep_q == CNT_W'(HEALTH_REP_LIMIT)) ? rep_q : rep_q + 1'b1;
    end else begin
      rep_next = CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q <= 1'b0;
      idx_q    <= '0;
      full_q   <= 1'b0;
      rep_q    <= '0;
      fail_q   <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= bus_i.req;
      if (wr_ctrl) begin
        enable_q <= bus_i.wdata[0];
      end
      // data read frees the holding word
      if (rd_data) begin
        full_q <= 1'b0;
      end
      // disabled source drops its partial word
      if (!enable_q) begin
        idx_q <= '0;
      end else if (take) begin
        idx_q <= idx_q + 1'b1;
        if (idx_q == IDX_W'(NIB_N - 1)) begin
          full_q <= 1'b1;
        end
      end
      // ctrl write restarts the health test
      if (wr_ctrl) begin
        rep_q  <= '0;
        fail_q <= 1'b0;
      end else if (take) begin
        rep_q <= rep_next;
        if (rep_next == CNT_W'(HEALTH_REP_LIMIT)) begin
          fail_q <= 1'b1;
        end
      end
    end
  end

  // sample payload
  always_ff @(posedge clk_i) begin
    if (take) begin
      pack_q <= pack_next;
      prev_q <= smp;
      if (idx_q == IDX_W'(NIB_N - 1)) begin
        hold_q <= pack_next;
      end
    end
  end

  // register reads
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      if (bus_i.we) begin
        rdata_q <= '0;
      end else begin
        case (bus_i.addr)
          REG_ES_CTRL:   rdata_q <= {{(BUS_DATA_W-1){1'b0}}, enable_q};
          REG_ES_STATUS: rdata_q <= {{(BUS_DATA_W-2){1'b0}}, fail_q, full_q};
          REG_ES_DATA:   rdata_q <= hold_q;
          default:       rdata_q <= '0;
        endcase
      end
    end
  end

  assign bus_i.ack   = ack_q;
  assign bus_i.rdata = rdata_q;

  // level interrupts
  assign intr_entropy_valid_o = full_q;
  assign intr_health_failed_o = fail_q;

endmodule

//--- rot_puf.sv
`timescale 1ns/1ps

module rot_puf
  import rot_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  rot_bus_if.device  bus_i,
  rot_rng_if.source  rng_o
);

  logic                  mode_q;
  logic [LFSR_W-1:0]     lfsr_q;
  logic [LFSR_W-1:0]     lfsr_step;
  logic [LFSR_W-1:0]     seed_val;
  logic                  step;
  logic                  wr_ctrl;
  logic                  wr_seed;
  logic                  done_q;
  logic [RNG_W-1:0]      nibble_q;
  logic                  ack_q;
  logic [BUS_DATA_W-1:0] rdata_q;

  // galois step, shift right and fold the taps on a set lsb
  assign lfsr_step = {1'b0, lfsr_q[LFSR_W-1:1]} ^ (lfsr_q[0] ? PUF_LFSR_TAPS : '0);

  // zero would lock up the lfsr
  assign seed_val = (bus_i.wdata[LFSR_W-1:0] == '0) ? PUF_SEED_RST
                                                    : bus_i.wdata[LFSR_W-1:0];

  // only step while the puf feeds the entropy source
  assign step = rng_o.es_rng_req && !mode_q;

  assign wr_ctrl = bus_i.req && bus_i.we && (bus_i.addr == REG_PUF_CTRL);
  assign wr_seed = bus_i.req && bus_i.we && (bus_i.addr == REG_PUF_SEED);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // external rng after reset
      mode_q <= 1'b1;
      lfsr_q <= PUF_SEED_RST;
      done_q <= 1'b0;
      ack_q  <= 1'b0;
    end else begin
      ack_q  <= bus_i.req;
      done_q <= step;
      if (wr_ctrl) begin
        mode_q <= bus_i.wdata[0];
      end
      // seed load wins over a step
      if (wr_seed) begin
        lfsr_q <= seed_val;
      end else if (step) begin
        lfsr_q <= lfsr_step;
      end
    end
  end

  // sample is the low nibble of the new state
  always_ff @(posedge clk_i) begin
    if (step) begin
      nibble_q <= lfsr_step[RNG_W-1:0];
    end
  end

  // register read back
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      if (bus_i.we) begin
        rdata_q <= '0;
      end else begin
        case (bus_i.addr)
          REG_PUF_CTRL: rdata_q <= {{(BUS_DATA_W-1){1'b0}}, mode_q};
          REG_PUF_SEED: rdata_q <= {{(BUS_DATA_W-LFSR_W){1'b0}}, lfsr_q};
          default:      rdata_q <= '0;
        endcase
      end
    end
  end

  assign bus_i.ack   = ack_q;
  assign bus_i.rdata = rdata_q;

  assign rng_o.rng4bit      = nibble_q;
  assign rng_o.rng4bit_done = done_q;
  assign rng_o.rng_mode     = mode_q;

endmodule

//--- rot_xbar.sv
`timescale 1ns/1ps

module rot_xbar
  import rot_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [BUS_ADDR_W-1:0] addr_i,
  input  logic [BUS_DATA_W-1:0] wdata_i,
  output logic [BUS_DATA_W-1:0] rdata_o,
  output logic                  ack_o,
  rot_bus_if.host               es_o,
  rot_bus_if.host               puf_o
);

  logic [SLOT_W-1:0]     slot;
  logic [OFF_W-1:0]      offset;
  logic                  hit_es;
  logic                  hit_puf;
  logic                  err_ack_q;
  logic [BUS_DATA_W-1:0] err_rdata_q;

  // address split into slot and word offset
  assign slot   = addr_i[BUS_ADDR_W-1 -: SLOT_W];
  assign offset = addr_i[OFF_W-1:0];
  assign hit_es  = (slot == SLOT_ES);
  assign hit_puf = (slot == SLOT_PUF);

  // strobe only to the addressed slot
  assign es_o.req   = req_i && hit_es;
  assign es_o.we    = we_i;
  assign es_o.addr  = offset;
  assign es_o.wdata = wdata_i;

  assign puf_o.req   = req_i && hit_puf;
  assign puf_o.we    = we_i;
  assign puf_o.addr  = offset;
  assign puf_o.wdata = wdata_i;

  // unmapped slot, answer locally one cycle later
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_ack_q <= 1'b0;
    end else begin
      err_ack_q <= req_i && !hit_es && !hit_puf;
    end
  end

  // error data only for reads
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      err_rdata_q <= we_i ? '0 : BUS_ERR_DATA;
    end
  end

  // one request outstanding, so at most one ack at a time
  assign ack_o = es_o.ack | puf_o.ack | err_ack_q;

  // response mux, zero when idle
  always_comb begin
    if (es_o.ack) begin
      rdata_o = es_o.rdata;
    end else if (puf_o.ack) begin
      rdata_o = puf_o.rdata;
    end else if (err_ack_q) begin
      rdata_o = err_rdata_q;
    end else begin
      rdata_o = '0;
    end
  end

endmodule

//--- rot_rng_if.sv
`timescale 1ns/1ps

// rng sample path between the puf and the entropy source
interface rot_rng_if
  import rot_pkg::*;
();

  // entropy source wants samples
  logic             es_rng_req;
  // puf nibble and its one cycle done strobe
  logic [RNG_W-1:0] rng4bit;
  logic             rng4bit_done;
  // 1 selects the external rng pins
  logic             rng_mode;

  modport source (input es_rng_req, output rng4bit, rng4bit_done, rng_mode);

  modport sink (output es_rng_req, input rng4bit, rng4bit_done, rng_mode);

endinterface

//--- rot_bus_if.sv
`timescale 1ns/1ps

// one register bus slot between the crossbar and a peripheral
interface rot_bus_if
  import rot_pkg::*;
();

  // request side, one cycle strobe
  logic                  req;
  logic                  we;
  // word offset only, slot already decoded
  logic [OFF_W-1:0]      addr;
  logic [BUS_DATA_W-1:0] wdata;

  // response, one cycle after req
  logic                  ack;
  // zero on writes
  logic [BUS_DATA_W-1:0] rdata;

  // crossbar side
  modport host (output req, we, addr, wdata, input ack, rdata);

  // peripheral side
  modport device (input req, we, addr, wdata, output ack, rdata);

endinterface

//--- rot_pkg.sv
package rot_pkg;

  // register bus geometry
  localparam int BUS_ADDR_W = 8;
  localparam int BUS_DATA_W = 32;

  // upper address bits pick the peripheral slot
  localparam int SLOT_W = 2;
  // remaining bits are the word offset inside a slot
  localparam int OFF_W = BUS_ADDR_W - SLOT_W;

  // slot map, slots 2 and 3 unmapped
  localparam logic [SLOT_W-1:0] SLOT_ES  = 2'd0;
  localparam logic [SLOT_W-1:0] SLOT_PUF = 2'd1;

  // read value returned by the crossbar for an unmapped slot
  localparam logic [BUS_DATA_W-1:0] BUS_ERR_DATA = 32'hbad0_acc5;

  // entropy source registers
  // ctrl bit0 enable
  localparam logic [OFF_W-1:0] REG_ES_CTRL   = 6'h00;
  // status bit0 word valid, bit1 health failed
  localparam logic [OFF_W-1:0] REG_ES_STATUS = 6'h01;
  // data read pops the held word
  localparam logic [OFF_W-1:0] REG_ES_DATA   = 6'h02;

  // puf registers
  // ctrl bit0 rng_mode, 1 selects the external rng
  localparam logic [OFF_W-1:0] REG_PUF_CTRL = 6'h00;
  // seed write loads the lfsr, read returns its state
  localparam logic [OFF_W-1:0] REG_PUF_SEED = 6'h01;

  // one rng sample is a nibble
  localparam int RNG_W = 4;

  // puf sample generator
  localparam int LFSR_W = 16;
  // galois mask for x^16 + x^14 + x^13 + x^11 + 1, right shifting
  localparam logic [LFSR_W-1:0] PUF_LFSR_TAPS = 16'hb400;
  // never zero, also loaded when a zero seed is written
  localparam logic [LFSR_W-1:0] PUF_SEED_RST = 16'hace1;

  // default repetition count limit for the health test
  localparam int HEALTH_REP_LIMIT_DEF = 6;

endpackage
